/* hdl/memPkg.sv */
package memPkg;

    localparam int addrW = 16;

    typedef logic [31:0] wordT;
    typedef logic [7:0]  byteT;

    typedef enum logic [1:0] {
        kindFetch = 2'd0,
        kindLoad  = 2'd1,
        kindStore = 2'd2
    } accKindE;

    typedef enum logic [1:0] {
        lenOne  = 2'd0,
        lenTwo  = 2'd1,
        lenFour = 2'd2
    } accLenE;

    typedef enum logic {
        clientFetch = 1'b0,
        clientData  = 1'b1
    } clientE;

    // number of RAM bytes touched by one access
    function automatic logic [2:0] lenBytes(accLenE len);
        case (len)
            lenOne:  return 3'd1;
            lenTwo:  return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

/* hdl/memReqIf.sv */
`timescale 1ns/10ps

interface memReqIf import memPkg::*; #(
    parameter int addrW = memPkg::addrW
);
    logic             valid;
    logic             ready;
    accKindE          kind;
    logic [addrW-1:0] addr;
    accLenE           len;
    wordT             wdata;

    // arbiter side
    modport arb (
        output valid,
        output kind,
        output addr,
        output len,
        output wdata,
        input  ready
    );

    modport seq (
        input  valid,
        input  kind,
        input  addr,
        input  len,
        input  wdata,
        output ready
    );

endinterface

/* hdl/memRspIf.sv */
`timescale 1ns/10ps

interface memRspIf import memPkg::*; ();
    logic   valid;
    logic   ready;
    clientE client;
    wordT   rdata;

    // sequencer offers, router accepts
    modport seq (
        output valid,
        output client,
        output rdata,
        input  ready
    );

    // ready depends on which slot the client maps to
    modport rtr (
        input  valid,
        input  client,
        input  rdata,
        output ready
    );

endinterface

/* hdl/reqArbiter.sv */
`timescale 1ns/10ps

module reqArbiter import memPkg::*; #(
    parameter int addrW = memPkg::addrW
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetchValid,
    output logic             fetchReady,
    input  logic [addrW-1:0] fetchAddr,
    input  logic             dataValid,
    output logic             dataReady,
    input  accKindE          dataKind,
    input  logic [addrW-1:0] dataAddr,
    input  accLenE           dataLen,
    input  wordT             dataWdata,
    memReqIf.arb             req
);

    logic held;
    logic heldData;
    logic pickData;

    // data first, unless a grant is still waiting for its transfer
    assign pickData = held ? heldData : dataValid;

    assign req.valid = pickData ? dataValid : fetchValid;
    assign req.kind  = pickData ? dataKind : kindFetch;
    assign req.addr  = pickData ? dataAddr : fetchAddr;
    assign req.len   = pickData ? dataLen : lenFour;
    assign req.wdata = pickData ? dataWdata : '0;

    assign dataReady  = req.ready && pickData;
    assign fetchReady = req.ready && !pickData;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else begin
            held <= req.valid && !req.ready;
        end
    end

    always_ff @(posedge clk) begin
        heldData <= pickData;
    end

    // clients must keep their request up and unchanged until taken
    assert property (@(posedge clk) disable iff (rst)
        req.valid && !req.ready |=>
            req.valid && $stable({req.kind, req.addr, req.len, req.wdata}))
        else $error("request changed before the sequencer took it");

endmodule

/* hdl/byteSequencer.sv */
`timescale 1ns/10ps

module byteSequencer import memPkg::*; #(
    parameter int addrW = memPkg::addrW
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    memReqIf.seq             req,
    memRspIf.seq             rsp,
    output logic             ramEn,
    output logic             ramWe,
    output logic [addrW-1:0] ramAddr,
    output byteT             ramWdata,
    input  byteT             ramRdata
);

    logic             reqRdy;
    logic             busy;
    logic [2:0]       cnt;
    logic             rdValid;
    logic [1:0]       rdIdx;
    logic             reqTake;
    logic             isStore;
    logic             lastWrite;

    accKindE          capKind;
    logic [addrW-1:0] capAddr;
    logic [2:0]       capBytes;
    wordT             shWord;
    wordT             asmWord;
    wordT             lastByte;

    assign reqTake   = req.valid && reqRdy;
    assign req.ready = reqRdy;
    assign isStore   = capKind == kindStore;

    // one byte per cycle until the length is used up
    assign ramEn     = busy && (cnt < capBytes) && !stall;
    assign ramWe     = ramEn && isStore;
    assign ramAddr   = capAddr + addrW'(cnt);
    assign ramWdata  = shWord[7:0];
    assign lastWrite = ramWe && (cnt == capBytes - 3'd1);

    // byte coming back from the RAM this cycle, at its little-endian slot
    assign lastByte = rdValid ? ({24'h0, ramRdata} << {rdIdx, 3'b000}) : '0;

    // store acks with its last write, loads once the last byte is back
    assign rsp.valid  = busy && ((cnt == capBytes) || lastWrite);
    assign rsp.client = (capKind == kindFetch) ? clientFetch : clientData;
    assign rsp.rdata  = asmWord | lastByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqRdy  <= 1'b0;
            busy    <= 1'b0;
            cnt     <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= ramEn && !ramWe;
            if (reqTake) begin
                reqRdy <= 1'b0;
                busy   <= 1'b1;
                cnt    <= '0;
            end else begin
                if (ramEn) begin
                    cnt <= cnt + 3'd1;
                end
                if (rsp.valid && rsp.ready) begin
                    busy   <= 1'b0;
                    reqRdy <= 1'b1;
                end else if (!busy) begin
                    reqRdy <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqTake) begin
            capKind  <= req.kind;
            capAddr  <= req.addr;
            capBytes <= lenBytes(req.len);
            shWord   <= req.wdata;
            // short loads come out zero-extended
            asmWord  <= '0;
        end else begin
            if (ramWe) begin
                shWord <= shWord >> 8;
            end
            if (rdValid) begin
                asmWord[8*rdIdx +: 8] <= ramRdata;
            end
        end
        rdIdx <= cnt[1:0];
    end

    // never a write while a read byte is on its way back
    assert property (@(posedge clk) disable iff (rst)
        ramWe |-> !rdValid)
        else $error("RAM write while a read byte was returning");

    assert property (@(posedge clk) disable iff (rst)
        busy |-> cnt <= capBytes)
        else $error("byte counter ran past the access length");

endmodule

/* hdl/byteRam.sv */
`timescale 1ns/10ps

module byteRam import memPkg::*; #(
    parameter int addrW    = memPkg::addrW,
    parameter int memDepth = 4096
) (
    input  logic             clk,
    input  logic             en,
    input  logic             we,
    input  logic [addrW-1:0] addr,
    input  byteT             wdata,
    output byteT             rdata
);

    localparam int idxW = $clog2(memDepth);

    byteT             mem [memDepth];
    logic [idxW-1:0]  idx;

    // depth is a power of two, upper address bits wrap
    assign idx = idxW'(addr);

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[idx] <= wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

/* hdl/respRouter.sv */
`timescale 1ns/10ps

module respRouter import memPkg::*; (
    input  logic clk,
    input  logic rst,
    memRspIf.rtr rsp,
    output logic instValid,
    input  logic instReady,
    output wordT inst,
    output logic loadValid,
    input  logic loadReady,
    output wordT loadData
);

    logic instFull;
    logic loadFull;
    logic takeInst;
    logic takeLoad;
    wordT instWord;
    wordT loadWord;

    // accept only into the named client's slot when it is empty
    assign rsp.ready = (rsp.client == clientFetch) ? !instFull : !loadFull;
    assign takeInst  = rsp.valid && rsp.ready && (rsp.client == clientFetch);
    assign takeLoad  = rsp.valid && rsp.ready && (rsp.client == clientData);

    assign instValid = instFull;
    assign inst      = instWord;
    assign loadValid = loadFull;
    assign loadData  = loadWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            instFull <= 1'b0;
            loadFull <= 1'b0;
        end else begin
            if (instFull && instReady) begin
                instFull <= 1'b0;
            end else if (takeInst) begin
                instFull <= 1'b1;
            end
            if (loadFull && loadReady) begin
                loadFull <= 1'b0;
            end else if (takeLoad) begin
                loadFull <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeInst) begin
            instWord <= rsp.rdata;
        end
        if (takeLoad) begin
            loadWord <= rsp.rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        loadValid && !loadReady |=> loadValid && $stable(loadData))
        else $error("load slot changed before handshake");

    // a waiting instruction stays put until the fetch side takes it
    assert property (@(posedge clk) disable iff (rst)
        instValid && !instReady |=> instValid && $stable(inst))
        else $error("instruction slot changed before handshake");

endmodule

/* hdl/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem import memPkg::*; #(
    parameter int addrW    = memPkg::addrW,
    parameter int memDepth = 4096
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetchValid,
    output logic             fetchReady,
    input  logic [addrW-1:0] fetchAddr,
    input  logic             dataValid,
    output logic             dataReady,
    input  accKindE          dataKind,
    input  logic [addrW-1:0] dataAddr,
    input  accLenE           dataLen,
    input  wordT             dataWdata,
    output logic             instValid,
    input  logic             instReady,
    output wordT             inst,
    output logic             loadValid,
    input  logic             loadReady,
    output wordT             loadData,
    input  logic             stall
);

    logic             ramEn;
    logic             ramWe;
    logic [addrW-1:0] ramAddr;
    byteT             ramWdata;
    byteT             ramRdata;

    memReqIf #(.addrW(addrW)) reqBus ();
    memRspIf rspBus ();

    reqArbiter #(.addrW(addrW)) u_arb (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchAddr  (fetchAddr),
        .dataValid  (dataValid),
        .dataReady  (dataReady),
        .dataKind   (dataKind),
        .dataAddr   (dataAddr),
        .dataLen    (dataLen),
        .dataWdata  (dataWdata),
        .req        (reqBus.arb)
    );

    byteSequencer #(.addrW(addrW)) u_seq (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .req      (reqBus.seq),
        .rsp      (rspBus.seq),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam #(.addrW(addrW), .memDepth(memDepth)) u_ram (
        .clk   (clk),
        .en    (ramEn),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    respRouter u_rtr (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rspBus.rtr),
        .instValid (instValid),
        .instReady (instReady),
        .inst      (inst),
        .loadValid (loadValid),
        .loadReady (loadReady),
        .loadData  (loadData)
    );

endmodule

/* dv/tbMemSubsystem.sv */
`timescale 1ns/10ps

module tbMemSubsystem import memPkg::*; ();

    localparam int resetCycles = 16;

    logic             clk;
    logic             rst;
    logic             fetchValid;
    logic             fetchReady;
    logic [addrW-1:0] fetchAddr;
    logic             dataValid;
    logic             dataReady;
    accKindE          dataKind;
    logic [addrW-1:0] dataAddr;
    accLenE           dataLen;
    wordT             dataWdata;
    logic             instValid;
    logic             instReady;
    wordT             inst;
    logic             loadValid;
    logic             loadReady;
    wordT             loadData;
    logic             stall;

    int               modeQ[$];
    int               clientQ[$];
    int               kindQ[$];
    int               lenQ[$];
    logic [addrW-1:0] addrQ[$];
    wordT             wdataQ[$];
    wordT             expQ[$];

    int               cyc;
    logic             noisy;
    logic [31:0]      lfsr;
    bit               loaded;

    memSubsystem #(.addrW(addrW), .memDepth(4096)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] stepLfsr(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic takeBit();
        lfsr = stepLfsr(lfsr);
        return lfsr[0];
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkInst(input wordT got, input wordT exp, input logic [addrW-1:0] a);
        if (got !== exp) begin
            abortRun($sformatf("FAIL %0t: fetch at %h gave %h, expected %h", $time, a, got, exp));
        end
    endtask

    task automatic checkLoad(input wordT got, input wordT exp, input logic [addrW-1:0] a);
        if (got !== exp) begin
            abortRun($sformatf("FAIL %0t: data access at %h gave %h, expected %h",
                $time, a, got, exp));
        end
    endtask

    task automatic runFetch(input logic [addrW-1:0] a, input wordT exp, input bit timed,
                            output int doneCyc);
        int startCyc;
        @(posedge clk);
        #1;
        fetchValid = 1'b1;
        fetchAddr  = a;
        @(negedge clk);
        while (!fetchReady) @(negedge clk);
        startCyc = cyc;
        @(posedge clk);
        #1 fetchValid = 1'b0;
        @(negedge clk);
        while (!(instValid && instReady)) @(negedge clk);
        doneCyc = cyc;
        checkInst(inst, exp, a);
        // 5 cycles in the sequencer plus 1 in the router
        if (timed && (doneCyc - startCyc != 6)) begin
            abortRun($sformatf("fetch at %h took %0d cycles instead of 6", a,
                doneCyc - startCyc));
        end
    endtask

    task automatic runData(input int k, input logic [addrW-1:0] a, input int len,
                           input wordT wd, input wordT exp, output int doneCyc);
        int   nb;
        int   freeCyc;
        logic lastFree;
        bit   badTiming;
        // length codes 0, 1 and 2 mean 1, 2 and 4 bytes
        nb       = 1 << len;
        freeCyc  = 0;
        lastFree = 1'b0;
        @(posedge clk);
        #1;
        dataValid = 1'b1;
        dataKind  = accKindE'(k);
        dataAddr  = a;
        dataLen   = accLenE'(len);
        dataWdata = wd;
        @(negedge clk);
        while (!dataReady) @(negedge clk);
        @(posedge clk);
        #1 dataValid = 1'b0;
        @(negedge clk);
        // unstalled cycles after the handshake until the result shows up
        while (!loadValid) begin
            lastFree = !stall;
            if (lastFree) begin
                freeCyc++;
            end
            @(negedge clk);
        end
        // a store acks with its last write, a load one cycle after its last read
        if (accKindE'(k) == kindStore) begin
            badTiming = (freeCyc != nb) || !lastFree;
        end else begin
            badTiming = (freeCyc - int'(lastFree)) != nb;
        end
        if (badTiming) begin
            abortRun($sformatf("data access at %h gave its result after %0d unstalled cycles",
                a, freeCyc));
        end
        while (!(loadValid && loadReady)) @(negedge clk);
        doneCyc = cyc;
        checkLoad(loadData, exp, a);
    endtask

    task automatic runLine(input int i, output int doneCyc);
        if (clientQ[i] == 0) begin
            runFetch(addrQ[i], expQ[i], modeQ[i] == 0, doneCyc);
        end else begin
            runData(kindQ[i], addrQ[i], lenQ[i], wdataQ[i], expQ[i], doneCyc);
        end
    endtask

    task automatic readStimulus();
        int    fd;
        int    n;
        int    m;
        int    c;
        int    k;
        int    l;
        string line;
        logic [addrW-1:0] a;
        wordT  wd;
        wordT  ex;
        fd = $fopen("dv/memStimulus.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the stimulus file dv/memStimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %d %d %h %d %h %h", m, c, k, a, l, wd, ex);
            // comment and blank lines do not parse
            if (n == 7) begin
                modeQ.push_back(m);
                clientQ.push_back(c);
                kindQ.push_back(k);
                addrQ.push_back(a);
                lenQ.push_back(l);
                wdataQ.push_back(wd);
                expQ.push_back(ex);
            end
        end
        $fclose(fd);
    endtask

    // back-pressure and stall
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (noisy) begin
                instReady = takeBit();
                loadReady = takeBit();
                stall     = takeBit();
                stall     = stall & takeBit();
            end else begin
                instReady = 1'b1;
                loadReady = 1'b1;
                stall     = 1'b0;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (resetCycles + 40 * modeQ.size()) @(posedge clk);
        abortRun("timeout: the DUT stopped returning results");
    end

    initial begin
        int i;
        int c0;
        int c1;
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchAddr = '0;
        dataValid = 1'b0;
        dataKind = kindLoad;
        dataAddr = '0;
        dataLen = lenOne;
        dataWdata = '0;
        instReady = 1'b1;
        loadReady = 1'b1;
        stall = 1'b0;
        cyc = 0;
        noisy = 1'b0;
        lfsr = 32'hac41_ad74;
        // byte depends on all 12 address bits
        for (int a = 0; a < 4096; a++) begin
            u_dut.u_ram.mem[a] = byteT'(a[7:0] ^ {a[11:8], a[11:8]});
        end
        readStimulus();
        loaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;

        i = 0;
        while (i < modeQ.size()) begin
            noisy = (modeQ[i] == 2);
            if (modeQ[i] == 1 && i + 1 < modeQ.size()) begin
                fork
                    runLine(i, c0);
                    runLine(i + 1, c1);
                join
                // data wins the arbitration
                if ((clientQ[i] == 1) ? (c0 >= c1) : (c1 >= c0)) begin
                    abortRun("fetch result arrived before the data result of the same pair");
                end
                i += 2;
            end else begin
                runLine(i, c0);
                i++;
            end
        end
        noisy = 1'b0;
        repeat (4) @(posedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* dv/memStimulus.txt */
# mode (0 quiet, 1 issued with next line, 2 random back-pressure and stall) client (0 fetch, 1 data)
# kind (0 fetch, 1 load, 2 store) addr(hex) len (0/1/2 = 1/2/4 bytes) wdata(hex) expected(hex)
0 1 2 0800 0 123456a5 00000000
0 1 1 0800 0 00000000 000000a5
0 1 1 0800 2 00000000 8b8a89a5
0 1 2 0810 1 1234beef 00000000
0 1 1 0810 1 00000000 0000beef
0 1 2 0820 2 deadc0de 00000000
0 1 1 0820 2 00000000 deadc0de
0 1 1 0822 1 00000000 0000dead
0 0 0 0100 2 00000000 12131011
0 0 0 0204 2 00000000 25242726
1 0 0 03f0 2 00000000 c0c1c2c3
1 1 1 0820 2 00000000 deadc0de
2 1 2 0830 2 cafef00d 00000000
2 1 1 0830 2 00000000 cafef00d
2 0 0 00a8 2 00000000 abaaa9a8
2 1 1 0831 1 00000000 0000fef0
2 1 2 0840 0 00000077 00000000
2 0 0 0100 2 00000000 12131011
2 1 1 0840 1 00000000 0000c977
2 1 1 0812 0 00000000 0000009a
2 0 0 0204 2 00000000 25242726

/* filelist.f */
hdl/memPkg.sv
hdl/memReqIf.sv
hdl/memRspIf.sv
hdl/reqArbiter.sv
hdl/byteSequencer.sv
hdl/byteRam.sv
hdl/respRouter.sv
hdl/memSubsystem.sv
dv/tbMemSubsystem.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module tbMemSubsystem -o simv

run: build
	./obj_dir/simv | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f filelist.f --top-module tbMemSubsystem

clean:
	rm -rf obj_dir $(LOG)
